// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/icache_pkg.sv
      - hdl/icache_snoop_if.sv
      - hdl/icache_array.sv
      - hdl/icache_prefetcher.sv
      - hdl/icache_mshr.sv
      - hdl/icache_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/icache_tb.sv

// ==== files.f ====
+incdir+include
hdl/icache_pkg.sv
hdl/icache_snoop_if.sv
hdl/icache_array.sv
hdl/icache_prefetcher.sv
hdl/icache_mshr.sv
hdl/icache_subsystem.sv
tests/icache_tb.sv

// ==== hdl/icache_array.sv ====
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_array import icache_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,

    // Fetch read ports with the older one at index 0
    input  logic [1:0]            i_read_valid,
    input  fetch_addr_t [1:0]     i_read_addr,
    output logic [1:0]            o_hit,
    output mem_block_t [1:0]      o_hit_data,

    icache_snoop_if.cache         snoop,

    // Fill from returned memory data
    input  logic                  i_fill_valid,
    input  line_tag_t             i_fill_tag,
    input  mem_block_t            i_fill_data,
    output logic                  o_full
);

    localparam int IDX_BITS = $clog2(`ICACHE_LINES);

    logic [`ICACHE_LINES-1:0] line_valid;
    line_tag_t                line_tag [`ICACHE_LINES];
    mem_block_t               line_data [`ICACHE_LINES];

    logic [IDX_BITS-1:0]      lfsr;
    logic [IDX_BITS-1:0]      free_idx;
    logic [IDX_BITS-1:0]      fill_idx;
    logic                     free_found;
    logic                     fill_tag_present;

    // Dual read, both ports compared against every line
    always_comb begin
        o_hit      = '0;
        o_hit_data = '0;
        for (int j = 0; j < 2; j++) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                if (i_read_valid[j] && line_valid[i] &&
                    (line_tag[i] == block_tag(i_read_addr[j]))) begin
                    o_hit[j]      = 1'b1;
                    o_hit_data[j] = line_data[i];
                end
            end
        end
    end

    // Snoop lookup for the prefetch candidate
    always_comb begin
        snoop.found_in_cache = 1'b0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            if (snoop.snoop_valid && line_valid[i] && (line_tag[i] == snoop.snoop_tag)) begin
                snoop.found_in_cache = 1'b1;
            end
        end
    end

    assign o_full = &line_valid;

    // Lowest free line wins, LFSR picks the victim otherwise
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = `ICACHE_LINES - 1; i >= 0; i--) begin
            if (!line_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_BITS'(i);
            end
        end
        fill_idx = free_found ? free_idx : lfsr;
    end

    // Fill tag already held by a valid line
    always_comb begin
        fill_tag_present = 1'b0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            if (line_valid[i] && (line_tag[i] == i_fill_tag)) begin
                fill_tag_present = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            line_valid <= '0;
            lfsr       <= IDX_BITS'(1);
        end else begin
            // x^3 + x^2 + 1 with period 7
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
            if (i_fill_valid) begin
                line_valid[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_fill_valid) begin
            line_tag[fill_idx]  <= i_fill_tag;
            line_data[fill_idx] <= i_fill_data;
        end
    end

    // Prefetch filter and MSHR together keep blocks unique in the cache
    a_fill_unique: assert property (@(posedge i_clock) disable iff (i_reset)
        i_fill_valid |-> !fill_tag_present)
        else $error("fill duplicates a cached tag");

endmodule

// ==== hdl/icache_mshr.sv ====
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_mshr import icache_pkg::*; (
    input  logic              i_clock,
    input  logic              i_reset,

    icache_snoop_if.mshr      snoop,

    // Request accepted by the arbiter
    input  logic              i_req_accepted,
    input  mem_tag_t          i_req_mem_tag,
    input  line_tag_t         i_req_tag,

    // Data return from memory
    input  mem_tag_t          i_mem_tag,
    output logic              o_fill_valid,
    output line_tag_t         o_fill_tag
);

    logic [`ICACHE_MSHR_DEPTH-1:0] ent_valid;
    mem_tag_t                      ent_mem_tag [`ICACHE_MSHR_DEPTH];
    line_tag_t                     ent_line_tag [`ICACHE_MSHR_DEPTH];

    mshr_ptr_t head;
    mshr_ptr_t tail;
    logic      push;
    logic      pop;

    assign push = i_req_accepted && (i_req_mem_tag != '0);

    // Memory returns in order, so only the head can match
    assign pop = (i_mem_tag != '0) && ent_valid[head] && (ent_mem_tag[head] == i_mem_tag);

    assign o_fill_valid = pop;
    assign o_fill_tag   = ent_line_tag[head];

    // Candidate already on its way from memory
    always_comb begin
        snoop.found_in_mshr = 1'b0;
        for (int i = 0; i < `ICACHE_MSHR_DEPTH; i++) begin
            if (snoop.snoop_valid && ent_valid[i] && (ent_line_tag[i] == snoop.snoop_tag)) begin
                snoop.found_in_mshr = 1'b1;
            end
        end
    end

    // Pointers wrap at the depth, which matches the pointer width
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ent_valid <= '0;
            head      <= '0;
            tail      <= '0;
        end else begin
            if (pop) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (push) begin
                ent_valid[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (push) begin
            ent_mem_tag[tail]  <= i_req_mem_tag;
            ent_line_tag[tail] <= i_req_tag;
        end
    end

    // Memory never has more tags in flight than the FIFO holds
    a_push_free: assert property (@(posedge i_clock) disable iff (i_reset)
        push |-> !ent_valid[tail])
        else $error("push onto an occupied entry");

endmodule

// ==== hdl/icache_pkg.sv ====
`include "icache_macros.svh"

package icache_pkg;

    // Byte address as seen by fetch and the arbiter
    typedef logic [`ICACHE_ADDR_BITS-1:0] fetch_addr_t;

    // Block-granular tag stored in each line
    typedef logic [`ICACHE_TAG_BITS-1:0] line_tag_t;

    // Data of one memory block
    typedef logic [`ICACHE_BLOCK_BITS-1:0] mem_block_t;

    // Memory transaction tag, zero means idle
    typedef logic [`ICACHE_MEM_TAG_BITS-1:0] mem_tag_t;

    // Head and tail pointers of the miss FIFO
    typedef logic [$clog2(`ICACHE_MSHR_DEPTH)-1:0] mshr_ptr_t;

    // Drop the offset bits of a byte address
    function automatic line_tag_t block_tag(input fetch_addr_t addr);
        return addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];
    endfunction

    // Rebuild a block-aligned byte address from a tag
    function automatic fetch_addr_t block_addr(input line_tag_t tag);
        return {tag, {`ICACHE_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

// ==== hdl/icache_prefetcher.sv ====
`timescale 1ns/10ps

module icache_prefetcher import icache_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,

    input  logic [1:0]            i_read_valid,
    input  fetch_addr_t [1:0]     i_read_addr,
    input  logic [1:0]            i_hit,
    input  logic                  i_cache_full,

    icache_snoop_if.prefetch      snoop,

    // Arbiter side
    input  logic                  i_req_accepted,
    output logic                  o_req_valid,
    output fetch_addr_t           o_req_addr
);

    logic      miss_valid;
    line_tag_t miss_tag;
    logic      new_miss;
    logic      accept;

    // Last requested miss and the stream pointer behind it
    logic      last_valid;
    line_tag_t last_tag;
    line_tag_t stream_tag;

    // Older missing read first
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = '0;
        if (i_read_valid[0] && !i_hit[0]) begin
            miss_valid = 1'b1;
            miss_tag   = block_tag(i_read_addr[0]);
        end else if (i_read_valid[1] && !i_hit[1]) begin
            miss_valid = 1'b1;
            miss_tag   = block_tag(i_read_addr[1]);
        end
    end

    assign new_miss = miss_valid && (!last_valid || (miss_tag != last_tag));

    // Candidate is the new miss, else the next sequential block
    always_comb begin
        snoop.snoop_valid = 1'b0;
        snoop.snoop_tag   = '0;
        if (new_miss) begin
            snoop.snoop_valid = 1'b1;
            snoop.snoop_tag   = miss_tag;
        end else if (last_valid && !i_cache_full) begin
            snoop.snoop_valid = 1'b1;
            snoop.snoop_tag   = stream_tag + 1'b1;
        end
    end

    assign o_req_valid = snoop.snoop_valid && !snoop.found_in_cache && !snoop.found_in_mshr;
    assign o_req_addr  = block_addr(snoop.snoop_tag);
    assign accept      = i_req_accepted && o_req_valid;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            last_valid <= 1'b0;
            last_tag   <= '0;
            stream_tag <= '0;
        end else if (accept) begin
            if (new_miss) begin
                last_valid <= 1'b1;
                last_tag   <= miss_tag;
                stream_tag <= miss_tag;
            end else begin
                stream_tag <= stream_tag + 1'b1;
            end
        end
    end

    // Arbiter must only accept a live request
    a_accept_legal: assert property (@(posedge i_clock) disable iff (i_reset)
        i_req_accepted |-> o_req_valid)
        else $error("accept without a pending request");

endmodule

// ==== hdl/icache_snoop_if.sv ====
`timescale 1ns/10ps

// Candidate lookup shared by the prefetcher, the cache and the MSHR
interface icache_snoop_if import icache_pkg::*; ();

    logic      snoop_valid;
    line_tag_t snoop_tag;
    logic      found_in_cache;
    logic      found_in_mshr;

    // Prefetcher proposes a block and reads back both results
    modport prefetch (
        output snoop_valid,
        output snoop_tag,
        input  found_in_cache,
        input  found_in_mshr
    );

    modport cache (
        input  snoop_valid,
        input  snoop_tag,
        output found_in_cache
    );

    modport mshr (
        input  snoop_valid,
        input  snoop_tag,
        output found_in_mshr
    );

endinterface

// ==== hdl/icache_subsystem.sv ====
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_subsystem import icache_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,

    // Fetch, index 0 is the older read
    input  logic [1:0]            i_read_valid,
    input  fetch_addr_t [1:0]     i_read_addr,
    output logic [1:0]            o_hit,
    output mem_block_t [1:0]      o_hit_data,

    // Arbiter
    output logic                  o_req_valid,
    output fetch_addr_t           o_req_addr,
    input  logic                  i_req_accepted,
    input  mem_tag_t              i_req_mem_tag,

    // Memory return
    input  mem_tag_t              i_mem_tag,
    input  mem_block_t            i_mem_data
);

    logic      cache_full;
    logic      fill_valid;
    line_tag_t fill_tag;

    icache_snoop_if snoop ();

    icache_array u_array (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_read_valid (i_read_valid),
        .i_read_addr  (i_read_addr),
        .o_hit        (o_hit),
        .o_hit_data   (o_hit_data),
        .snoop        (snoop.cache),
        .i_fill_valid (fill_valid),
        .i_fill_tag   (fill_tag),
        .i_fill_data  (i_mem_data),
        .o_full       (cache_full)
    );

    icache_prefetcher u_prefetcher (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_read_valid   (i_read_valid),
        .i_read_addr    (i_read_addr),
        .i_hit          (o_hit),
        .i_cache_full   (cache_full),
        .snoop          (snoop.prefetch),
        .i_req_accepted (i_req_accepted),
        .o_req_valid    (o_req_valid),
        .o_req_addr     (o_req_addr)
    );

    // Line tag of the request goes along with the memory tag
    icache_mshr u_mshr (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .snoop          (snoop.mshr),
        .i_req_accepted (i_req_accepted),
        .i_req_mem_tag  (i_req_mem_tag),
        .i_req_tag      (o_req_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS]),
        .i_mem_tag      (i_mem_tag),
        .o_fill_valid   (fill_valid),
        .o_fill_tag     (fill_tag)
    );

endmodule

// ==== include/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Byte address width of a fetch request
`define ICACHE_ADDR_BITS 32

// Offset bits inside one memory block (8 bytes per block)
`define ICACHE_OFFSET_BITS 3

// Block tag, the address with its offset bits dropped
`define ICACHE_TAG_BITS (`ICACHE_ADDR_BITS - `ICACHE_OFFSET_BITS)

// One memory block
`define ICACHE_BLOCK_BITS 64

// Fully associative line count
`define ICACHE_LINES 8

// Memory transaction tag, zero is reserved for "no transaction"
`define ICACHE_MEM_TAG_BITS 4

// FIFO depth covers the whole tag space
`define ICACHE_MSHR_DEPTH 16

`endif

// ==== tests/icache_patterns.txt ====
// Columns: read valid 0, read address 0, read valid 1, read address 1,
// expected hit at once on port 0 and on port 1. A line starting with F ends the list.
1_00001000_1_00001004_0_0
1_00001008_1_00001010_1_1
1_00001038_1_00001020_1_1
0_00000000_1_00001018_0_1
1_00001030_0_00000000_1_0
1_00001024_1_0000102C_1_1
1_0000100C_1_0000100C_1_1
1_00001034_1_00001008_1_1
F_00000000_F_00000000_0_0

// ==== tests/icache_tb.sv ====
`timescale 1ns/10ps
`include "icache_macros.svh"

module icache_tb import icache_pkg::*; ();

    localparam int MAX_LINES = 32;
    localparam int WAIT_LIMIT = 400;
    localparam fetch_addr_t BLOCK_BYTES = fetch_addr_t'(1) << `ICACHE_OFFSET_BITS;

    logic              clock;
    logic              reset;
    logic [1:0]        read_valid;
    fetch_addr_t [1:0] read_addr;
    logic [1:0]        hit;
    mem_block_t [1:0]  hit_data;
    logic              req_valid;
    fetch_addr_t       req_addr;
    logic              req_accepted;
    mem_tag_t          req_mem_tag;
    mem_tag_t          mem_tag;
    mem_block_t        mem_data;

    // DUT outputs as seen at the last falling edge
    logic              s_req_valid;
    fetch_addr_t       s_req_addr;
    logic [1:0]        s_hit;
    mem_block_t [1:0]  s_hit_data;

    // Arbiter and memory model, one request in flight
    logic              busy;
    mem_tag_t          next_tag;
    mem_tag_t          flight_tag;
    fetch_addr_t       flight_addr;
    int                latency_left;
    int                stall_left;
    fetch_addr_t       held_addr;
    fetch_addr_t       expect_req;
    fetch_addr_t       requested [$];
    logic              ret_seen;
    fetch_addr_t       ret_addr;

    logic [79:0]       patterns [MAX_LINES];

    icache_subsystem i_dut (
        .i_clock        (clock),
        .i_reset        (reset),
        .i_read_valid   (read_valid),
        .i_read_addr    (read_addr),
        .o_hit          (hit),
        .o_hit_data     (hit_data),
        .o_req_valid    (req_valid),
        .o_req_addr     (req_addr),
        .i_req_accepted (req_accepted),
        .i_req_mem_tag  (req_mem_tag),
        .i_mem_tag      (mem_tag),
        .i_mem_data     (mem_data)
    );

    always #50 clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_hit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_data(input string name, input mem_block_t actual,
                              input mem_block_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_addr(input string name, input fetch_addr_t actual,
                              input fetch_addr_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic fetch_addr_t block_base(input fetch_addr_t addr);
        return addr & ~(BLOCK_BYTES - 1);
    endfunction

    // Memory returns the block address followed by its inverse
    function automatic mem_block_t block_contents(input fetch_addr_t base);
        return {base, ~base};
    endfunction

    task automatic accept_request();
        foreach (requested[i]) begin
            if (requested[i] == s_req_addr) begin
                abort_run($sformatf("block %h was requested a second time", s_req_addr));
            end
        end
        check_addr("o_req_addr", s_req_addr, expect_req);
        requested.push_back(s_req_addr);
        expect_req   = expect_req + BLOCK_BYTES;
        req_accepted = 1'b1;
        req_mem_tag  = next_tag;
        flight_tag   = next_tag;
        flight_addr  = s_req_addr;
        next_tag     = (next_tag == '1) ? mem_tag_t'(1) : next_tag + 1'b1;
        latency_left = $urandom % 6;
        busy         = 1'b1;
        stall_left   = -1;
    endtask

    // Sample at the falling edge, then drive the arbiter and memory side
    task automatic next_cycle();
        @(negedge clock);
        s_req_valid = req_valid;
        s_req_addr  = req_addr;
        s_hit       = hit;
        s_hit_data  = hit_data;
        // A fill shows up one cycle after its return cycle
        if (ret_seen) begin
            for (int j = 0; j < 2; j++) begin
                if (read_valid[j] && (block_base(read_addr[j]) == ret_addr)) begin
                    check_hit($sformatf("o_hit[%0d]", j), s_hit[j], 1'b1);
                    check_data($sformatf("o_hit_data[%0d]", j), s_hit_data[j],
                               block_contents(ret_addr));
                end
            end
        end
        ret_seen     = 1'b0;
        req_accepted = 1'b0;
        req_mem_tag  = '0;
        mem_tag      = '0;
        if (busy) begin
            if (latency_left > 0) begin
                latency_left--;
            end else begin
                mem_tag  = flight_tag;
                mem_data = block_contents(flight_addr);
                busy     = 1'b0;
                ret_seen = 1'b1;
                ret_addr = flight_addr;
            end
        end else if (s_req_valid) begin
            if (requested.size() == `ICACHE_LINES) begin
                abort_run("request issued although the cache is already full");
            end
            if (stall_left < 0) begin
                stall_left = $urandom % 4;
                held_addr  = s_req_addr;
            end else begin
                check_addr("o_req_addr", s_req_addr, held_addr);
            end
            if (stall_left == 0) begin
                accept_request();
            end else begin
                stall_left--;
            end
        end else begin
            stall_left = -1;
        end
    endtask

    task automatic check_ports(input logic [1:0] valid, input logic must_hit);
        for (int j = 0; j < 2; j++) begin
            if (!valid[j] || must_hit) begin
                check_hit($sformatf("o_hit[%0d]", j), s_hit[j], valid[j]);
            end
            if (s_hit[j]) begin
                check_data($sformatf("o_hit_data[%0d]", j), s_hit_data[j],
                           block_contents(block_base(read_addr[j])));
            end
        end
    endtask

    task automatic apply_line(input int idx);
        logic [79:0] p;
        logic [1:0]  valid;
        logic [1:0]  at_once;
        int          miss_port;
        int          waited;
        p            = patterns[idx];
        valid        = {p[40], p[76]};
        at_once      = {p[0], p[4]};
        read_valid   = valid;
        read_addr[0] = p[75:44];
        read_addr[1] = p[39:8];
        miss_port    = -1;
        if (valid[0] && !at_once[0]) begin
            miss_port = 0;
        end else if (valid[1] && !at_once[1]) begin
            miss_port = 1;
        end
        if (miss_port >= 0) begin
            expect_req = block_base(read_addr[miss_port]);
        end
        next_cycle();
        for (int j = 0; j < 2; j++) begin
            check_hit($sformatf("o_hit[%0d]", j), s_hit[j], valid[j] && at_once[j]);
        end
        check_ports(valid, 1'b0);
        // Oldest miss goes out in the same cycle
        if (miss_port >= 0) begin
            check_hit("o_req_valid", s_req_valid, 1'b1);
            check_addr("o_req_addr", s_req_addr, block_base(read_addr[miss_port]));
        end
        waited = 0;
        while ((s_hit & valid) != valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for the hits of pattern line %0d", idx));
            end
            waited++;
            next_cycle();
            check_ports(valid, 1'b0);
        end
        // Sequential stream runs until the cache is full
        waited = 0;
        while (busy || s_req_valid) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("timeout waiting for requests to stop after line %0d", idx));
            end
            waited++;
            next_cycle();
            check_ports(valid, 1'b1);
        end
    endtask

    initial begin
        int   idx;
        logic done;
        clock        = 1'b0;
        reset        = 1'b1;
        read_valid   = '0;
        read_addr    = '0;
        req_accepted = 1'b0;
        req_mem_tag  = '0;
        mem_tag      = '0;
        mem_data     = '0;
        busy         = 1'b0;
        next_tag     = mem_tag_t'(1);
        stall_left   = -1;
        ret_seen     = 1'b0;
        expect_req   = '0;
        void'($urandom(51815));
        $readmemh("tests/icache_patterns.txt", patterns);
        repeat (3) @(negedge clock);
        reset = 1'b0;

        next_cycle();
        check_hit("o_req_valid", s_req_valid, 1'b0);
        check_hit("o_hit[0]", s_hit[0], 1'b0);
        check_hit("o_hit[1]", s_hit[1], 1'b0);

        idx  = 0;
        done = 1'b0;
        while (!done) begin
            if ((idx == MAX_LINES) || (^patterns[idx] === 1'bx)) begin
                abort_run("pattern file missing or without its end marker");
            end
            if (patterns[idx][79:76] == 4'hF) begin
                done = 1'b1;
            end else begin
                apply_line(idx);
                idx++;
            end
        end

        if (requested.size() != `ICACHE_LINES) begin
            abort_run($sformatf("expected %0d block requests, saw %0d",
                                `ICACHE_LINES, requested.size()));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
